// File: source/icachePkg.sv
// Types and geometry shared by every block of the instruction cache
// Compile this package first, each RTL module imports it inside its body
// The typedefs fix a 64-byte line, 128 lines and 4 ways
package icachePkg;

	// ==================================================
	// Address and data widths
	// ==================================================

	// A physical byte address, ip and invalidate addresses alike
	typedef logic [31:0] address_t;

	// Upper address bits that are kept in the tag store
	typedef logic [18:0] tag_t;

	// Line index, address bits 12 down to 6
	typedef logic [6:0] lineIdx_t;

	// Word within a line, address bits 5 down to 2
	typedef logic [3:0] wordSel_t;

	// Way number inside a set
	typedef logic [1:0] way_t;

	// One instruction word as returned to the requester
	typedef logic [31:0] insn_t;

	// A whole 64-byte line as delivered by memory in one strobe
	typedef logic [511:0] line_t;

	// ==================================================
	// Line geometry
	// ==================================================

	// Byte offset bits inside a line
	localparam int lineOffsetBits = 6;

	// Byte offset bits inside a word
	localparam int wordOffsetBits = 2;

	// Lowest tag bit, just above the line index
	localparam int tagLsb = lineOffsetBits + $bits(lineIdx_t);

	// ==================================================
	// Request structs
	// ==================================================

	// Fill of one line into one way, built by the top level on memAck
	typedef struct packed {
		way_t     way;
		address_t lineAddr;
		line_t    data;
	} fillReq_t;

	// Invalidate command, line and all are mutually exclusive under ce
	typedef struct packed {
		logic     ce;
		logic     line;
		logic     all;
		address_t adr;
	} invReq_t;

endpackage

// File: source/icacheValid.sv
// Valid bits of the instruction cache, one bit per way and line
// A fill sets the bit of the filled way, an invalidate clears one index or all
// The bits of every way at the lookup index are presented combinationally
module icacheValid #(
	parameter int LINES = 128,
	parameter int WAYS = 4
) (
	input  logic                clk,
	input  logic                rst,
	input  icachePkg::fillReq_t fill,
	input  logic                wr,
	input  icachePkg::invReq_t  inv,
	input  icachePkg::lineIdx_t lineIdx,
	output logic [WAYS-1:0]     validWays
);
	import icachePkg::*;

	// One row per line, each row holds one bit per way
	logic [WAYS-1:0] validMem [LINES];

	// Index of the line being filled
	lineIdx_t fillIdx;

	// Index named by a line invalidate
	lineIdx_t invIdx;

	assign fillIdx = fill.lineAddr[lineOffsetBits +: $bits(lineIdx_t)];
	assign invIdx = inv.adr[lineOffsetBits +: $bits(lineIdx_t)];

	// ==================================================
	// Update, fill first and invalidate second
	// ==================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int n = 0; n < LINES; n++) begin
				validMem[n] <= '0;
			end
		end else if (wr) begin
			// A fill wins over any invalidate arriving in the same cycle
			validMem[fillIdx][fill.way] <= 1'b1;
		end else if (inv.ce) begin
			if (inv.line) begin
				// Every way of the named index goes invalid at once
				validMem[invIdx] <= '0;
			end else if (inv.all) begin
				for (int n = 0; n < LINES; n++) begin
					validMem[n] <= '0;
				end
			end
		end
	end

	// Lookup side, all ways of the indexed line
	assign validWays = validMem[lineIdx];

	// The requester never asks for both kinds of invalidate in one command
	invKindExclusive: assert property (
		@(posedge clk) disable iff (rst)
		inv.ce |-> !(inv.line && inv.all)
	);

endmodule

// File: source/icacheTags.sv
// Tag store of the instruction cache, one tag per way and line
// A fill writes the tag bits of the line address into the filled way
// The lookup compares one tag against every way of an index in parallel
// and hands back a per-way match vector, the top level qualifies it
// with the valid bits to get the real hit vector
module icacheTags #(
	parameter int LINES = 128,
	parameter int WAYS = 4
) (
	input  logic                clk,
	input  icachePkg::fillReq_t fill,
	input  logic                wr,
	input  icachePkg::tag_t     lookupTag,
	input  icachePkg::lineIdx_t lineIdx,
	output logic [WAYS-1:0]     tagMatch
);
	import icachePkg::*;

	// ==================================================
	// Storage
	// ==================================================

	// Tags are plain storage, the valid array says whether they mean anything
	tag_t tagMem [WAYS][LINES];

	// Index and tag carried by the fill address
	lineIdx_t fillIdx;
	tag_t     fillTag;

	assign fillIdx = fill.lineAddr[lineOffsetBits +: $bits(lineIdx_t)];
	assign fillTag = fill.lineAddr[tagLsb +: $bits(tag_t)];

	// Only the way named by the replacement pointer is written
	always_ff @(posedge clk) begin
		if (wr) begin
			tagMem[fill.way][fillIdx] <= fillTag;
		end
	end

	// ==================================================
	// Parallel compare
	// ==================================================

	// Each way of the indexed set is read and compared independently
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			tagMatch[w] = (tagMem[w][lineIdx] == lookupTag);
		end
	end

	// A write becomes visible to the compare on the edge after the fill,
	// which is exactly when the top level repeats the lookup

endmodule

// File: source/icacheReplace.sv
// Round-robin replacement pointers of the instruction cache
// Each line keeps its own pointer, which names the next victim way
// The pointer of the filled line advances on every fill and wraps
// Invalidates leave the pointers alone
module icacheReplace #(
	parameter int LINES = 128,
	parameter int WAYS = 4
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                wr,
	input  icachePkg::lineIdx_t fillIdx,
	output icachePkg::way_t     victim
);
	import icachePkg::*;

	// One pointer per line
	way_t ptrMem [LINES];

	// Pointer of the line under fill and its successor
	way_t curPtr;
	way_t nextPtr;

	assign curPtr = ptrMem[fillIdx];

	// Wrap at the last way so a narrower set also cycles correctly
	always_comb begin
		if (curPtr == way_t'(WAYS - 1)) begin
			nextPtr = '0;
		end else begin
			nextPtr = curPtr + 1'b1;
		end
	end

	// ==================================================
	// Pointer update
	// ==================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int n = 0; n < LINES; n++) begin
				ptrMem[n] <= '0;
			end
		end else if (wr) begin
			ptrMem[fillIdx] <= nextPtr;
		end
	end

	// The way the current fill goes into
	assign victim = curPtr;

endmodule

// File: source/icacheLineData.sv
// Line data of the instruction cache, one 64-byte line per way and index
// A fill writes a whole line into the filled way in one cycle
// The read side picks one 32-bit word out of the hitting way's line
// Word k of a line sits at bits 32k+31 down to 32k
module icacheLineData #(
	parameter int LINES = 128,
	parameter int WAYS = 4
) (
	input  logic                clk,
	input  icachePkg::fillReq_t fill,
	input  logic                wr,
	input  icachePkg::lineIdx_t lineIdx,
	input  icachePkg::way_t     hitWay,
	input  icachePkg::wordSel_t wordSel,
	output icachePkg::insn_t    word
);
	import icachePkg::*;

	// ==================================================
	// Storage
	// ==================================================

	line_t dataMem [WAYS][LINES];

	// Index of the line being written
	lineIdx_t fillIdx;

	assign fillIdx = fill.lineAddr[lineOffsetBits +: $bits(lineIdx_t)];

	// Memory always returns the full line, so no byte enables are needed
	always_ff @(posedge clk) begin
		if (wr) begin
			dataMem[fill.way][fillIdx] <= fill.data;
		end
	end

	// ==================================================
	// Word read
	// ==================================================

	// Line of the hitting way at the lookup index
	line_t hitLine;

	assign hitLine = dataMem[hitWay][lineIdx];

	// Word select is a plain indexed part select over the line
	always_comb begin
		word = hitLine[wordSel * $bits(insn_t) +: $bits(insn_t)];
	end

	// On a miss hitWay is zero and the word is simply not used upstream

endmodule

// File: source/instCache.sv
// Set-associative instruction cache, top level
// Holds fetchReq high with ip to fetch, insnValid pulses with the word
// On a miss one line request goes out on missReq/missAdr and the
// returned line is written on memAck before the lookup is repeated
// Sets LINES and WAYS for the four arrays below it
module instCache #(
	parameter int LINES = 128,
	parameter int WAYS = 4
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                fetchReq,
	input  icachePkg::address_t ip,
	output logic                insnValid,
	output icachePkg::insn_t    insn,
	output logic                missReq,
	output icachePkg::address_t missAdr,
	input  logic                memAck,
	input  icachePkg::line_t    memLine,
	input  icachePkg::invReq_t  inv
);
	import icachePkg::*;

	// Lookup in Idle, one dead cycle in Respond, parked in WaitFill on a miss
	typedef enum logic [1:0] {
		Idle,
		Respond,
		WaitFill
	} state_t;

	state_t state;

	// ==================================================
	// Lookup address split
	// ==================================================

	lineIdx_t lookupIdx;
	tag_t     lookupTag;
	wordSel_t wordSel;

	assign lookupIdx = ip[lineOffsetBits +: $bits(lineIdx_t)];
	assign lookupTag = ip[tagLsb +: $bits(tag_t)];
	assign wordSel = ip[wordOffsetBits +: $bits(wordSel_t)];

	// Per-way results from the valid and tag arrays
	logic [WAYS-1:0] validWays;
	logic [WAYS-1:0] tagMatch;
	logic [WAYS-1:0] hitVec;
	logic            hit;
	way_t            hitWay;
	insn_t           hitWord;

	// A way hits only when its tag matches and its line is valid
	assign hitVec = validWays & tagMatch;
	assign hit = |hitVec;

	// Encode the hitting way, at most one bit is ever set
	always_comb begin
		hitWay = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (hitVec[w]) begin
				hitWay = way_t'(w);
			end
		end
	end

	// ==================================================
	// Fill path
	// ==================================================

	way_t     victim;
	lineIdx_t fillIdx;
	fillReq_t fill;

	// The fill always targets the line that missed last
	assign fillIdx = missAdr[lineOffsetBits +: $bits(lineIdx_t)];

	always_comb begin
		fill.way = victim;
		fill.lineAddr = missAdr;
		fill.data = memLine;
	end

	// ==================================================
	// Control FSM
	// ==================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= Idle;
			insnValid <= 1'b0;
			missReq <= 1'b0;
		end else begin
			// Both outputs are single-cycle pulses
			insnValid <= 1'b0;
			missReq <= 1'b0;
			case (state)
				Idle: begin
					if (fetchReq && hit) begin
						insnValid <= 1'b1;
						state <= Respond;
					end else if (fetchReq) begin
						missReq <= 1'b1;
						state <= WaitFill;
					end
				end
				// Gives the requester one cycle to present the next ip
				Respond: state <= Idle;
				// Line lands on this edge, the lookup is repeated next edge
				WaitFill: begin
					if (memAck) begin
						state <= Idle;
					end
				end
				default: state <= Idle;
			endcase
		end
	end

	// Output word and miss address registers
	always_ff @(posedge clk) begin
		if (state == Idle && fetchReq && hit) begin
			insn <= hitWord;
		end
		if (state == Idle && fetchReq && !hit) begin
			missAdr <= {ip[$bits(address_t)-1:lineOffsetBits], {lineOffsetBits{1'b0}}};
		end
	end

	// ==================================================
	// Arrays
	// ==================================================

	icacheValid #(.LINES(LINES), .WAYS(WAYS)) uValid (
		.clk      (clk),
		.rst      (rst),
		.fill     (fill),
		.wr       (memAck),
		.inv      (inv),
		.lineIdx  (lookupIdx),
		.validWays(validWays)
	);

	icacheTags #(.LINES(LINES), .WAYS(WAYS)) uTags (
		.clk      (clk),
		.fill     (fill),
		.wr       (memAck),
		.lookupTag(lookupTag),
		.lineIdx  (lookupIdx),
		.tagMatch (tagMatch)
	);

	icacheReplace #(.LINES(LINES), .WAYS(WAYS)) uReplace (
		.clk    (clk),
		.rst    (rst),
		.wr     (memAck),
		.fillIdx(fillIdx),
		.victim (victim)
	);

	icacheLineData #(.LINES(LINES), .WAYS(WAYS)) uLineData (
		.clk    (clk),
		.fill   (fill),
		.wr     (memAck),
		.lineIdx(lookupIdx),
		.hitWay (hitWay),
		.wordSel(wordSel),
		.word   (hitWord)
	);

	// A line is never cached in two ways, tags and valid bits agree on that
	hitOneWay: assert property (
		@(posedge clk) disable iff (rst)
		(state == Idle && fetchReq) |-> $onehot0(hitVec)
	);

	// Memory only answers a request that is still outstanding
	ackOnlyInFill: assert property (
		@(posedge clk) disable iff (rst)
		memAck |-> state == WaitFill
	);

endmodule

// File: testbench/icacheMemModel.sv
// Memory model for the instruction cache testbench
// Answers each missReq with one memAck pulse and a whole computed line
// The answer comes 2 to 9 cycles later, the delay drawn from a private LCG
module icacheMemModel (
	input  logic                clk,
	input  logic                rst,
	input  logic                missReq,
	input  icachePkg::address_t missAdr,
	output logic                memAck,
	output icachePkg::line_t    memLine
);
	timeunit 1ns;
	timeprecision 100ps;
	import icachePkg::*;

	// State of the delay generator, separate from the stimulus generator
	logic [31:0] delayState;

	// Advances the delay LCG and returns the new state
	function logic [31:0] nextDelayRand();
		delayState = delayState * 32'd1664525 + 32'd1013904223;
		return delayState;
	endfunction

	// Word k of line address A holds A plus 4k, XORed with a fixed pattern
	function automatic line_t buildLine(input address_t base);
		line_t l;
		for (int k = 0; k < 16; k++) begin
			l[32*k +: 32] = (base + 32'(4 * k)) ^ 32'h5a5a_0000;
		end
		return l;
	endfunction

	initial begin
		int delay;
		logic [31:0] r;
		address_t reqAdr;
		delayState = 32'h2a77_2be2;
		memAck = 1'b0;
		memLine = '0;
		forever begin
			// missReq and missAdr are both stable at the falling edge
			@(negedge clk);
			if (!rst && missReq) begin
				reqAdr = missAdr;
				r = nextDelayRand();
				delay = 2 + int'(r[18:16]);
				repeat (delay) @(posedge clk);
				#10;
				memAck = 1'b1;
				memLine = buildLine(reqAdr);
				@(posedge clk);
				#10;
				memAck = 1'b0;
			end
		end
	end

endmodule

// File: testbench/instCacheTb.sv
// Testbench for the set-associative instruction cache
// Runs directed fetch and invalidate tests against a reference model
// of the valid bits, tags and round-robin pointers
// Compile with the file list and run instCacheTb as the top module
module instCacheTb;
	timeunit 1ns;
	timeprecision 100ps;
	import icachePkg::*;

	// Cycles a single fetch may take before it counts as lost
	localparam int fetchLimit = 40;
	localparam int watchdogCyclesPerFetch = 400;

	logic     clk;
	logic     rst;
	logic     fetchReq;
	address_t ip;
	logic     insnValid;
	insn_t    insn;
	logic     missReq;
	address_t missAdr;
	logic     memAck;
	line_t    memLine;
	invReq_t  inv;

	int          errors;
	int          checks;
	int          fetchesIssued;
	logic [31:0] lcgState;

	// Reference model of the valid bits, tags and pointers per line and way
	bit   tbValid [128][4];
	tag_t tbTag [128][4];
	way_t tbPtr [128];

	instCache #(.LINES(128), .WAYS(4)) UUT (
		.clk      (clk),
		.rst      (rst),
		.fetchReq (fetchReq),
		.ip       (ip),
		.insnValid(insnValid),
		.insn     (insn),
		.missReq  (missReq),
		.missAdr  (missAdr),
		.memAck   (memAck),
		.memLine  (memLine),
		.inv      (inv)
	);

	icacheMemModel memory (
		.clk    (clk),
		.rst    (rst),
		.missReq(missReq),
		.missAdr(missAdr),
		.memAck (memAck),
		.memLine(memLine)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	// ==================================================
	// Helpers
	// ==================================================

	function logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic address_t makeAddr(input tag_t tag, input lineIdx_t idx, input wordSel_t w);
		return {tag, idx, w, 2'b00};
	endfunction

	// True when the model holds the line of addr in a valid way
	function automatic bit modelHit(input address_t addr);
		bit found;
		found = 1'b0;
		for (int w = 0; w < 4; w++) begin
			if (tbValid[addr[12:6]][w] && tbTag[addr[12:6]][w] == addr[31:13]) begin
				found = 1'b1;
			end
		end
		return found;
	endfunction

	task automatic reportMismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		errors++;
		$display("Mismatch at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
	endtask

	// Fetches one address, checks word, miss count and missAdr, then updates the model
	task automatic fetch(input address_t addr);
		lineIdx_t idx;
		address_t lineBase;
		insn_t    expWord;
		bit       expHit;
		bit       done;
		int       missCount;
		int       waited;
		idx = addr[12:6];
		lineBase = {addr[31:6], 6'b0};
		expWord = (lineBase + 32'(4 * addr[5:2])) ^ 32'h5a5a_0000;
		expHit = modelHit(addr);
		done = 1'b0;
		missCount = 0;
		waited = 0;
		@(posedge clk);
		#10;
		fetchReq = 1'b1;
		ip = addr;
		fetchesIssued++;
		while (!done && waited < fetchLimit) begin
			@(negedge clk);
			waited++;
			if (missReq) begin
				missCount++;
				checks++;
				if (missAdr !== lineBase) reportMismatch("missAdr", lineBase, missAdr);
			end
			if (insnValid) begin
				done = 1'b1;
				checks++;
				if (insn !== expWord) reportMismatch("insn", expWord, insn);
			end
		end
		if (!done) begin
			errors++;
			$display("Fetch of %h got no insnValid within %0d cycles", addr, fetchLimit);
		end
		checks++;
		if (missCount != (expHit ? 0 : 1)) begin
			reportMismatch("missReq count", expHit ? 0 : 1, missCount);
		end
		// A miss fills the way under the pointer, which then moves on
		if (!expHit) begin
			tbTag[idx][tbPtr[idx]] = addr[31:13];
			tbValid[idx][tbPtr[idx]] = 1'b1;
			tbPtr[idx] = tbPtr[idx] + 1'b1;
		end
		@(posedge clk);
		#10;
		fetchReq = 1'b0;
	endtask

	task automatic invalidate(input bit allLines, input address_t addr);
		@(posedge clk);
		#10;
		inv.ce = 1'b1;
		inv.line = !allLines;
		inv.all = allLines;
		inv.adr = addr;
		@(posedge clk);
		#10;
		inv = '0;
		// Pointers survive an invalidate, only valid bits go
		for (int n = 0; n < 128; n++) begin
			for (int w = 0; w < 4; w++) begin
				if (allLines || n == int'(addr[12:6])) tbValid[n][w] = 1'b0;
			end
		end
	endtask

	// ==================================================
	// Directed tests
	// ==================================================

	task automatic coldFetchTest();
		fetch(makeAddr(19'h00123, 7'd13, 4'd3));
		fetch(makeAddr(19'h00123, 7'd13, 4'd3));
		fetch(makeAddr(19'h00123, 7'd13, 4'd9));
	endtask

	// Tags 10 to 13 take ways 0 to 3, tag 14 then evicts way 0
	task automatic victimTest();
		for (int t = 0; t < 5; t++) begin
			fetch(makeAddr(19'h10 + 19'(t), 7'd5, 4'(t)));
		end
		// Tag 10 comes back into way 1 and pushes tag 11 out
		fetch(makeAddr(19'h10, 7'd5, 4'd0));
		for (int t = 2; t < 5; t++) begin
			fetch(makeAddr(19'h10 + 19'(t), 7'd5, 4'd7));
		end
	endtask

	// Index 5 holds tags 10, 12, 13 and 14 in its four ways before the invalidate
	task automatic lineInvalidateTest();
		invalidate(1'b0, makeAddr(19'h0, 7'd5, 4'd0));
		fetch(makeAddr(19'h10, 7'd5, 4'd1));
		fetch(makeAddr(19'h12, 7'd5, 4'd8));
		fetch(makeAddr(19'h13, 7'd5, 4'd2));
		fetch(makeAddr(19'h14, 7'd5, 4'd15));
		fetch(makeAddr(19'h00123, 7'd13, 4'd3));
	endtask

	task automatic allInvalidateTest();
		invalidate(1'b1, '0);
		fetch(makeAddr(19'h00123, 7'd13, 4'd3));
		fetch(makeAddr(19'h10, 7'd5, 4'd1));
		fetch(makeAddr(19'h12, 7'd5, 4'd11));
		fetch(makeAddr(19'h13, 7'd5, 4'd6));
		fetch(makeAddr(19'h14, 7'd5, 4'd4));
	endtask

	// Eight tags over eight indices keep both hits and evictions frequent
	task automatic randomTest();
		logic [31:0] r;
		for (int i = 0; i < 200; i++) begin
			r = nextRand();
			if (r[15:12] == 4'd0) begin
				invalidate(r[11] && r[10], makeAddr('0, 7'(r[9:7]), '0));
			end
			fetch(makeAddr(19'h40 + 19'(r[30:28]), 7'(r[26:24]), r[21:18]));
		end
	endtask

	// ==================================================
	// Main sequence and watchdog
	// ==================================================

	initial begin
		fetchReq = 1'b0;
		ip = '0;
		inv = '0;
		rst = 1'b1;
		errors = 0;
		checks = 0;
		fetchesIssued = 0;
		lcgState = 32'h2a77_2be2;
		for (int n = 0; n < 128; n++) begin
			tbPtr[n] = '0;
			for (int w = 0; w < 4; w++) begin
				tbValid[n][w] = 1'b0;
				tbTag[n][w] = '0;
			end
		end
		repeat (8) @(posedge clk);
		#10;
		rst = 1'b0;
		coldFetchTest();
		victimTest();
		lineInvalidateTest();
		allInvalidateTest();
		randomTest();
		repeat (4) @(posedge clk);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	// Budget grows with every fetch, so a stuck fetch runs out of it
	initial begin
		int cycles;
		cycles = 0;
		while (cycles < (fetchesIssued + 1) * watchdogCyclesPerFetch) begin
			@(posedge clk);
			cycles++;
		end
		errors++;
		$display("Timeout after %0d cycles with %0d fetches issued", cycles, fetchesIssued);
		$display("Checks: %0d, errors: %0d", checks, errors);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: instCache.f
source/icachePkg.sv
source/icacheValid.sv
source/icacheTags.sv
source/icacheReplace.sv
source/icacheLineData.sv
source/instCache.sv
testbench/icacheMemModel.sv
testbench/instCacheTb.sv
